//--- ppu.f
+incdir+include
verilog/ppu_pkg.sv
verilog/pipe_align.sv
verilog/gamma_lut.sv
verilog/vdemux.sv
verilog/ppu_ctrl.sv
verilog/ppu_top.sv
sim/tb_clk_gen.sv
sim/tb_ppu_top.sv

//--- sim/tb_ppu_top.sv
// ============================================================
// Testbench for the PPU that drives console bus fields of
// short lines, models the expected RGB, syncs, DE and video
// info, and compares every pixel at the fixed pipeline latency
// ============================================================

`timescale 1ns/1ps

`include "ppu_defines.svh"

module tb_ppu_top;

  // Blue word to output change through demux and gamma
  localparam int LATENCY     = 1 + `PPU_GAMMA_LAT;
  localparam int WORDS_LINE  = 20;
  localparam int TOTAL_LINES = 3 * 6 + 6 + 2 * 6 + 3 * 296 + 2 * (262 + 263);
  localparam int MAX_CYCLES  = 8 + 7 * 9 + TOTAL_LINES * WORDS_LINE + 200;

  logic                  VCLK_Tx;
  logic                  nVRST_Tx;
  logic                  nvdsync;
  ppu_pkg::color_in_t    vd;
  ppu_pkg::deblur_mode_t deblur_mode;
  logic                  mode15;
  logic [1:0]            gamma;
  ppu_pkg::vinfo_t       info;
  logic                  vde;
  logic                  hsync;
  logic                  vsync;
  logic [23:0]           vd_out;

  // Expected stream of due cycle, RGB and {de, hsync, vsync}
  int          due_q[$];
  logic [23:0] pix_q[$];
  logic [2:0]  ctl_q[$];

  integer             seed = 32'h6edb2ae2;
  int                 cyc = 0;
  logic               seen_pixel = 1'b0;
  // Video info model
  logic               m_hs = 1'b1;
  logic               m_vs = 1'b1;
  int                 m_cnt = 0;
  int                 m_prev = 0;
  logic               m_pal = 1'b0;
  logic               m_int = 1'b0;
  logic               m_deb = 1'b0;
  int                 line_pos = 0;
  ppu_pkg::color_in_t last_r;
  ppu_pkg::color_in_t last_g;
  ppu_pkg::color_in_t last_b;

  tb_clk_gen u_clk_gen (
    .clk_o   (VCLK_Tx),
    .rst_n_o (nVRST_Tx)
  );

  ppu_top u_ppu_top (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .nvdsync_i     (nvdsync),
    .vd_i          (vd),
    .deblur_mode_i (deblur_mode),
    .mode15_i      (mode15),
    .gamma_i       (gamma),
    .info_o        (info),
    .vde_o         (vde),
    .hsync_o       (hsync),
    .vsync_o       (vsync),
    .vd_o          (vd_out)
  );

  // ==========================================================
  // Reference model
  // ==========================================================

  // Optional LSB drop, MSB copied below, then the gamma curve
  function automatic logic [7:0] shape_channel(input ppu_pkg::color_in_t c,
                                               input logic m15, input logic [1:0] gsel);
    ppu_pkg::color_in_t m;
    logic [7:0]         e;
    m = m15 ? (c & 7'h7e) : c;
    e = {m, m[6]};
    case (gsel)
      2'd1:    return e + (8'd255 - e) / 4;
      2'd2:    return e - e / 4;
      default: return e;
    endcase
  endfunction

  function automatic logic [23:0] ref_pixel(input ppu_pkg::color_in_t r,
                                            input ppu_pkg::color_in_t g,
                                            input ppu_pkg::color_in_t b,
                                            input logic m15, input logic [1:0] gsel);
    return {shape_channel(r, m15, gsel), shape_channel(g, m15, gsel),
            shape_channel(b, m15, gsel)};
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("=== FAIL ===");
    $fatal(1, "Mismatch on %s", name);
  endtask

  task automatic report_error(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "Run aborted");
  endtask

  // Line count per field and mode decision at each vsync fall
  task automatic track_syncs(input logic hs, input logic vs);
    if (m_vs && !vs) begin
      m_pal = (m_cnt > `PPU_PAL_LINES);
      m_int = (m_cnt != m_prev);
      case (deblur_mode)
        ppu_pkg::DEBLUR_ON:  m_deb = 1'b1;
        ppu_pkg::DEBLUR_OFF: m_deb = 1'b0;
        default:             m_deb = !m_int;
      endcase
      m_prev = m_cnt;
      m_cnt  = 0;
    end else if (m_hs && !hs) begin
      m_cnt++;
    end
    m_hs = hs;
    m_vs = vs;
  endtask

  // ==========================================================
  // Stimulus
  // ==========================================================

  task automatic send_pixel(input logic hs, input logic vs);
    ppu_pkg::color_in_t r;
    ppu_pkg::color_in_t g;
    ppu_pkg::color_in_t b;
    r = 7'($random(seed));
    g = 7'($random(seed));
    b = 7'($random(seed));
    track_syncs(hs, vs);
    // hsync pixel is position 0 and deblur repeats even positions
    line_pos = hs ? line_pos + 1 : 0;
    if (m_deb && hs && (line_pos % 2 == 0)) begin
      r = last_r;
      g = last_g;
      b = last_b;
    end
    last_r = r;
    last_g = g;
    last_b = b;
    @(posedge VCLK_Tx);
    nvdsync <= 1'b0;
    vd      <= {3'b000, vs, 1'b1, hs, hs & vs};
    @(posedge VCLK_Tx);
    nvdsync <= 1'b1;
    vd      <= r;
    @(posedge VCLK_Tx);
    vd <= g;
    @(posedge VCLK_Tx);
    vd <= b;
    due_q.push_back(cyc + 1 + LATENCY);
    pix_q.push_back(ref_pixel(r, g, b, mode15, gamma));
    ctl_q.push_back({hs & vs, hs, vs});
  endtask

  // Line 0 carries vsync on its four active pixels
  task automatic send_field(input int lines);
    for (int l = 0; l < lines; l++) begin
      if (l == 1) begin
        assert (info == {m_pal, m_int, m_deb})
          else report_value("info_o", info, {m_pal, m_int, m_deb});
      end
      send_pixel(1'b0, 1'b1);
      for (int p = 0; p < 4; p++) begin
        send_pixel(1'b1, l != 0);
      end
    end
  endtask

  // Idle gap lets the pipeline drain before settings move
  task automatic configure(input ppu_pkg::deblur_mode_t dm, input logic m15,
                           input logic [1:0] gsel);
    repeat (6) @(posedge VCLK_Tx);
    deblur_mode <= dm;
    mode15      <= m15;
    gamma       <= gsel;
    repeat (2) @(posedge VCLK_Tx);
  endtask

  initial begin
    nvdsync     = 1'b1;
    vd          = '0;
    deblur_mode = ppu_pkg::DEBLUR_OFF;
    mode15      = 1'b0;
    gamma       = 2'd0;
    wait (nVRST_Tx == 1'b1);
    repeat (2) @(posedge VCLK_Tx);
    // NTSC, progressive, deblur off until the first vsync fall
    assert (info == 3'b000) else report_value("info_o", info, 3'b000);
    // Linear, brighten, darken with deblur off
    for (int gsel = 0; gsel < 3; gsel++) begin
      configure(ppu_pkg::DEBLUR_OFF, 1'b0, 2'(gsel));
      send_field(6);
    end
    configure(ppu_pkg::DEBLUR_OFF, 1'b1, 2'd1);
    send_field(6);
    // Forced deblur takes effect at the first vsync fall
    configure(ppu_pkg::DEBLUR_ON, 1'b0, 2'd0);
    send_field(6);
    send_field(6);
    // Auto mode with progressive PAL fields
    configure(ppu_pkg::DEBLUR_AUTO, 1'b0, 2'd0);
    repeat (3) send_field(296);
    assert (info.pal == 1'b1) else report_value("info_o.pal", info.pal, 1'b1);
    // Auto mode with 480i field lengths
    configure(ppu_pkg::DEBLUR_AUTO, 1'b0, 2'd2);
    repeat (2) begin
      send_field(262);
      send_field(263);
    end
    assert (info.interlaced == 1'b1)
      else report_value("info_o.interlaced", info.interlaced, 1'b1);
    assert (info.deblur == 1'b0) else report_value("info_o.deblur", info.deblur, 1'b0);
    while (due_q.size() != 0) begin
      @(posedge VCLK_Tx);
    end
    repeat (4) @(posedge VCLK_Tx);
    $display("=== PASS ===");
    $finish;
  end

  // ==========================================================
  // Output compare half a cycle after each rising edge
  // ==========================================================

  always @(negedge VCLK_Tx) begin
    cyc = cyc + 1;
    assert (cyc < MAX_CYCLES) else report_error("Timeout: pixel stream did not complete");
    if (nVRST_Tx) begin
      if (due_q.size() != 0 && due_q[0] == cyc) begin
        seen_pixel = 1'b1;
        assert (vd_out == pix_q[0]) else report_value("vd_o", vd_out, pix_q[0]);
        assert (vde == ctl_q[0][2]) else report_value("vde_o", vde, ctl_q[0][2]);
        assert (hsync == ctl_q[0][1]) else report_value("hsync_o", hsync, ctl_q[0][1]);
        assert (vsync == ctl_q[0][0]) else report_value("vsync_o", vsync, ctl_q[0][0]);
        void'(due_q.pop_front());
        void'(pix_q.pop_front());
        void'(ctl_q.pop_front());
      end else begin
        // DE only in the due cycle of a pixel
        assert (vde == 1'b0) else report_value("vde_o", vde, 1'b0);
        if (!seen_pixel) begin
          assert ({vd_out, hsync, vsync} == '0)
            else report_error("Outputs not zero between reset and first pixel");
        end
      end
    end
  end

endmodule

//--- sim/tb_clk_gen.sv
// ============================================================
// Clock and reset source for the PPU testbench
// 8 ns VCLK_Tx, nVRST_Tx held low for the first 8 rising edges
// ============================================================

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Release on a rising edge, like the rest of the stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- verilog/ppu_top.sv
// ============================================================
// PPU top level taking the console video bus to 24-bit RGB
// with syncs and DE; control, demux, gamma and side-band
// alignment all run on VCLK_Tx
// ============================================================

`timescale 1ns/1ps

`include "ppu_defines.svh"

module ppu_top (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  logic                  nvdsync_i,
  input  ppu_pkg::color_in_t    vd_i,
  input  ppu_pkg::deblur_mode_t deblur_mode_i,
  input  logic                  mode15_i,
  input  logic [1:0]            gamma_i,
  output ppu_pkg::vinfo_t       info_o,
  output logic                  vde_o,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output logic [23:0]           vd_o
);

  logic [1:0]        phase;
  logic              deblur;
  logic              mode15;
  ppu_pkg::pix_in_t  pix_dmx;
  ppu_pkg::sync_t    sync_dmx;
  logic              pix_valid;
  ppu_pkg::pix_out_t pix_gam;
  ppu_pkg::sync_t    sync_hold_q;
  ppu_pkg::sync_t    sync_in;
  ppu_pkg::sync_t    sync_dly;
  logic              de_in;

  ppu_ctrl u_ppu_ctrl (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .nvdsync_i     (nvdsync_i),
    .vd_sync_i     (vd_i[3:0]),
    .deblur_mode_i (deblur_mode_i),
    .mode15_i      (mode15_i),
    .phase_o       (phase),
    .deblur_o      (deblur),
    .mode15_o      (mode15),
    .vinfo_o       (info_o)
  );

  vdemux u_vdemux (
    .VCLK_Tx     (VCLK_Tx),
    .nVRST_Tx    (nVRST_Tx),
    .vd_i        (vd_i),
    .phase_i     (phase),
    .deblur_i    (deblur),
    .mode15_i    (mode15),
    .pix_o       (pix_dmx),
    .sync_o      (sync_dmx),
    .pix_valid_o (pix_valid)
  );

  gamma_lut u_gamma_lut (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .gamma_i  (gamma_i),
    .pix_i    (pix_dmx),
    .pix_o    (pix_gam)
  );

  // ==========================================================
  // Side-band alignment
  // ==========================================================

  // Syncs only move on pixel pulses and hold in between
  always_ff @(posedge VCLK_Tx) begin
    if (!nVRST_Tx) begin
      sync_hold_q <= '0;
    end else if (pix_valid) begin
      sync_hold_q <= sync_dmx;
    end
  end

  assign sync_in = pix_valid ? sync_dmx : sync_hold_q;

  // DE only for pixels outside both blanking syncs
  assign de_in = pix_valid && sync_dmx.nvsync && sync_dmx.nhsync;

  pipe_align #(
    .T     (ppu_pkg::sync_t),
    .DEPTH (`PPU_GAMMA_LAT)
  ) u_sync_align (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .d_i      (sync_in),
    .q_o      (sync_dly)
  );

  pipe_align #(
    .T     (logic),
    .DEPTH (`PPU_GAMMA_LAT)
  ) u_de_align (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .d_i      (de_in),
    .q_o      (vde_o)
  );

  assign hsync_o = sync_dly.nhsync;
  assign vsync_o = sync_dly.nvsync;
  assign vd_o    = {pix_gam.r, pix_gam.g, pix_gam.b};

endmodule

//--- verilog/ppu_ctrl.sv
// ============================================================
// Bus phase tracking, video mode detection and deblur decision
// Phase output steers the demultiplexer; vinfo goes to the top
// ============================================================

`timescale 1ns/1ps

`include "ppu_defines.svh"

module ppu_ctrl (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  logic                  nvdsync_i,
  input  ppu_pkg::sync_t        vd_sync_i,
  input  ppu_pkg::deblur_mode_t deblur_mode_i,
  input  logic                  mode15_i,
  output logic [1:0]            phase_o,
  output logic                  deblur_o,
  output logic                  mode15_o,
  output ppu_pkg::vinfo_t       vinfo_o
);

  logic [1:0]                 phase_q;
  ppu_pkg::sync_t             sync_q;
  logic [`PPU_LINE_CNT_W-1:0] line_cnt_q;
  logic [`PPU_LINE_CNT_W-1:0] prev_cnt_q;
  logic                       hsync_fall;
  logic                       vsync_fall;
  ppu_pkg::vinfo_t            vinfo_q;

  // ==========================================================
  // Bus phase
  // ==========================================================

  // Sync word whenever the strobe is low, else the counted phase
  assign phase_o = nvdsync_i ? phase_q : 2'd0;

  // Counter parks at 0 after blue until the next strobe
  always_ff @(posedge VCLK_Tx) begin
    if (!nVRST_Tx) begin
      phase_q <= 2'd0;
    end else if (!nvdsync_i) begin
      phase_q <= 2'd1;
    end else if (phase_q != 2'd0) begin
      phase_q <= phase_q + 2'd1;
    end
  end

  // ==========================================================
  // Sync edges and line counting
  // ==========================================================

  // Edges only seen on sync words
  assign hsync_fall = !nvdsync_i && sync_q.nhsync && !vd_sync_i.nhsync;
  assign vsync_fall = !nvdsync_i && sync_q.nvsync && !vd_sync_i.nvsync;

  always_ff @(posedge VCLK_Tx) begin
    if (!nVRST_Tx) begin
      // Idle bus, all syncs inactive
      sync_q     <= '1;
      line_cnt_q <= '0;
      prev_cnt_q <= '0;
    end else begin
      if (!nvdsync_i) begin
        sync_q <= vd_sync_i;
      end
      if (vsync_fall) begin
        // Field done, keep its length for the interlace check
        prev_cnt_q <= line_cnt_q;
        line_cnt_q <= '0;
      end else if (hsync_fall && (line_cnt_q != '1)) begin
        line_cnt_q <= line_cnt_q + 1'b1;
      end
    end
  end

  // ==========================================================
  // Video info and deblur
  // ==========================================================

  always_ff @(posedge VCLK_Tx) begin
    if (!nVRST_Tx) begin
      // NTSC, progressive, deblur off
      vinfo_q <= '0;
      mode15_o <= 1'b0;
    end else begin
      mode15_o <= mode15_i;
      if (vsync_fall) begin
        vinfo_q.pal        <= (line_cnt_q > `PPU_PAL_LINES);
        // Odd/even field lengths differ in 480i
        vinfo_q.interlaced <= (line_cnt_q != prev_cnt_q);
        unique case (deblur_mode_i)
          ppu_pkg::DEBLUR_ON:  vinfo_q.deblur <= 1'b1;
          ppu_pkg::DEBLUR_OFF: vinfo_q.deblur <= 1'b0;
          // Auto: only progressive content gets deblurred
          default:             vinfo_q.deblur <= (line_cnt_q == prev_cnt_q);
        endcase
      end
    end
  end

  assign deblur_o = vinfo_q.deblur;
  assign vinfo_o  = vinfo_q;

  // Strobe must not cut into red or green of a running pixel
  a_no_short_pixel : assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (phase_q inside {2'd1, 2'd2}) |-> nvdsync_i
  );

endmodule

//--- verilog/vdemux.sv
// ============================================================
// Splits the multiplexed bus words into one pixel per pulse
// Applies deblur repetition and the 15-bit colour mask
// ============================================================

`timescale 1ns/1ps

module vdemux (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  ppu_pkg::color_in_t vd_i,
  input  logic [1:0]         phase_i,
  input  logic               deblur_i,
  input  logic               mode15_i,
  output ppu_pkg::pix_in_t   pix_o,
  output ppu_pkg::sync_t     sync_o,
  output logic               pix_valid_o
);

  ppu_pkg::color_in_t vd_masked;
  ppu_pkg::color_in_t red_q;
  ppu_pkg::color_in_t green_q;
  ppu_pkg::sync_t     sync_cur_q;
  logic               repeat_q;
  logic               do_repeat;

  // 15-bit mode drops the colour LSB
  assign vd_masked = vd_i & ~ppu_pkg::color_in_t'(mode15_i);

  // Repeat only inside a line, never on the hsync pixel itself
  assign do_repeat = deblur_i && repeat_q && sync_cur_q.nhsync;

  // Sync nibble and first two colours of the pixel
  always_ff @(posedge VCLK_Tx) begin
    case (phase_i)
      2'd0:    sync_cur_q <= vd_i[3:0];
      2'd1:    red_q      <= vd_masked;
      2'd2:    green_q    <= vd_masked;
      default: ;
    endcase
  end

  // ==========================================================
  // Pixel output on blue
  // ==========================================================

  always_ff @(posedge VCLK_Tx) begin
    if (!nVRST_Tx) begin
      pix_valid_o <= 1'b0;
      repeat_q    <= 1'b0;
      pix_o       <= '0;
      sync_o      <= '1;
    end else begin
      pix_valid_o <= (phase_i == 2'd3);
      if (phase_i == 2'd3) begin
        sync_o <= sync_cur_q;
        // Deblurred pixel keeps the previous colours
        if (!do_repeat) begin
          pix_o.r <= red_q;
          pix_o.g <= green_q;
          pix_o.b <= vd_masked;
        end
        // hsync pixel restarts the odd/even pattern
        repeat_q <= sync_cur_q.nhsync ? ~repeat_q : 1'b0;
      end
    end
  end

  // A full sync, R, G, B sequence lies between two pixels
  a_pix_spacing : assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    pix_valid_o |=> !pix_valid_o [*3]
  );

endmodule

//--- verilog/gamma_lut.sv
// ============================================================
// Two-stage gamma: expand 7-bit colour to 8 bits, then apply
// the selected curve; runs freely, validity travels alongside
// ============================================================

`timescale 1ns/1ps

`include "ppu_defines.svh"

module gamma_lut (
  input  logic              VCLK_Tx,
  input  logic              nVRST_Tx,
  input  logic [1:0]        gamma_i,
  input  ppu_pkg::pix_in_t  pix_i,
  output ppu_pkg::pix_out_t pix_o
);

  ppu_pkg::pix_out_t exp_q;
  ppu_pkg::pix_out_t gam_nxt;

  // Append MSB as new LSB, so full scale maps to 255
  function automatic ppu_pkg::color_out_t expand(input ppu_pkg::color_in_t c);
    return {c, c[`PPU_COLOR_W_I-1]};
  endfunction

  // 1 lifts towards white, 2 pulls towards black, 0 passes
  function automatic ppu_pkg::color_out_t apply(input ppu_pkg::color_out_t e,
                                                input logic [1:0]          sel);
    ppu_pkg::color_out_t full;
    full = {`PPU_COLOR_W_O{1'b1}};
    case (sel)
      2'd1:    return e + ((full - e) >> 2);
      2'd2:    return e - (e >> 2);
      default: return e;
    endcase
  endfunction

  // Stage 1 expansion
  always_ff @(posedge VCLK_Tx) begin
    if (!nVRST_Tx) begin
      exp_q <= '0;
    end else begin
      exp_q.r <= expand(pix_i.r);
      exp_q.g <= expand(pix_i.g);
      exp_q.b <= expand(pix_i.b);
    end
  end

  always_comb begin
    gam_nxt.r = apply(exp_q.r, gamma_i);
    gam_nxt.g = apply(exp_q.g, gamma_i);
    gam_nxt.b = apply(exp_q.b, gamma_i);
  end

  // Stage 2 curve
  always_ff @(posedge VCLK_Tx) begin
    if (!nVRST_Tx) begin
      pix_o <= '0;
    end else begin
      pix_o <= gam_nxt;
    end
  end

  // Setting 3 has no curve defined
  a_gamma_sel : assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx) gamma_i != 2'd3
  );

endmodule

//--- verilog/pipe_align.sv
// ============================================================
// Delay line for side-band data that follows the gamma stage
// Instantiated once per payload type with the gamma latency
// ============================================================

`timescale 1ns/1ps

module pipe_align #(
  parameter type T     = logic,
  parameter int  DEPTH = 2
) (
  input  logic VCLK_Tx,
  input  logic nVRST_Tx,
  input  T     d_i,
  output T     q_o
);

  // One entry per pixel in flight
  T stage_q [DEPTH];

  always_ff @(posedge VCLK_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[DEPTH-1];

endmodule

//--- verilog/ppu_pkg.sv
// ============================================================
// Shared types of the PPU: sync flags, pixels, video info
// Referenced by scoped names from every RTL module
// ============================================================

`include "ppu_defines.svh"

package ppu_pkg;

  // Single colour words
  typedef logic [`PPU_COLOR_W_I-1:0] color_in_t;
  typedef logic [`PPU_COLOR_W_O-1:0] color_out_t;

  // Sync nibble, bits 3 down to 0, all active low
  typedef struct packed {
    logic nvsync;
    logic nclamp;
    logic nhsync;
    logic ncsync;
  } sync_t;

  // Demultiplexed pixel at bus width
  typedef struct packed {
    color_in_t r;
    color_in_t g;
    color_in_t b;
  } pix_in_t;

  // Pixel after expansion and gamma
  typedef struct packed {
    color_out_t r;
    color_out_t g;
    color_out_t b;
  } pix_out_t;

  // Detected video mode plus resulting deblur state
  typedef struct packed {
    logic pal;
    logic interlaced;
    logic deblur;
  } vinfo_t;

  typedef enum logic [1:0] {
    DEBLUR_AUTO = 2'd0,
    DEBLUR_OFF  = 2'd1,
    DEBLUR_ON   = 2'd2
  } deblur_mode_t;

endpackage

//--- include/ppu_defines.svh
// ============================================================
// Global widths, latencies and thresholds for the video PPU
// Included by the package, the control logic and the gamma stage
// ============================================================

`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// Colour word on the console bus
`define PPU_COLOR_W_I 7

// Colour channel towards the HDMI transmitter
`define PPU_COLOR_W_O 8

// Cycles through the gamma stage
`define PPU_GAMMA_LAT 2

// Fields with more lines than this are PAL
`define PPU_PAL_LINES 290

// Line counter width, enough for a full PAL field
`define PPU_LINE_CNT_W 10

`endif
